//--- src/display_pkg.sv
// screen timing and framebuffer geometry constants
package display_pkg;

    // framebuffer geometry
    localparam int fb_width  = 16;                  // columns
    localparam int fb_height = 8;                   // rows
    localparam int fb_pixels = fb_width * fb_height; // memory depth
    localparam int fb_addrw  = 7;                   // enough for fb_pixels
    localparam int cordw     = 16;                  // signed drawing coords

    // output replication, same in both axes
    localparam int scale     = 2;

    // screen timing, one pixel per clk_sys
    localparam int h_active  = 32;                  // fb_width * scale
    localparam int h_total   = 48;                  // incl. horizontal blanking
    localparam int v_active  = 16;                  // fb_height * scale
    localparam int v_total   = 20;                  // incl. vertical blanking

    // screen counter widths
    localparam int scr_xw    = 6;                   // holds h_total-1
    localparam int scr_yw    = 5;                   // holds v_total-1

    // read address to line buffer write
    // memory read, index reg, palette reg
    localparam int fill_lat  = 3;

endpackage

//--- src/colour_pkg.sv
// colour index, channel and palette word widths
package colour_pkg;

    localparam int cidxw     = 4;           // colour index bits, 16 colours
    localparam int chanw     = 4;           // bits per r/g/b channel
    localparam int palw      = 3 * chanw;   // {red, green, blue}
    localparam int pal_depth = 16;          // 2**cidxw entries

endpackage

//--- src/display_timing.sv
// screen position counters
// decodes data enable, line and frame pulses
module display_timing (
    input  logic                           clk_sys,
    input  logic                           rst_sys,
    output logic                           de,      // active pixel
    output logic                           frame,   // start of last blank line
    output logic                           line,    // start of every line
    output logic [display_pkg::scr_yw-1:0] sy       // screen line
);

    logic [display_pkg::scr_xw-1:0] sx;             // screen column

    // x wraps every line, y wraps every frame
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            sx <= '0;
            sy <= display_pkg::scr_yw'(display_pkg::v_total - 1); // frame due next
        end else begin
            if (sx == display_pkg::h_total - 1) begin
                sx <= '0;
                if (sy == display_pkg::v_total - 1) begin
                    sy <= '0;                       // back to first active line
                end else begin
                    sy <= sy + 1'b1;
                end
            end else begin
                sx <= sx + 1'b1;
            end
        end
    end

    // decode straight from the counters
    always_comb begin
        de    = (sx < display_pkg::h_active) && (sy < display_pkg::v_active);
        line  = (sx == '0);
        frame = (sx == '0) && (sy == display_pkg::v_total - 1); // in blanking
    end

    // counters stay inside one frame, every decode relies on it
    a_counters_in_range : assert property (
        @(posedge clk_sys) disable iff (rst_sys)
        (sx < display_pkg::h_total) && (sy < display_pkg::v_total)
    );

endmodule

//--- src/bram_sdp.sv
// simple dual-port memory
// one write port, one registered read port
module bram_sdp #(
    parameter int width = 4,                    // word bits
    parameter int depth = 128                   // words
) (
    input  logic                     clk_sys,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] addr_write,
    input  logic [$clog2(depth)-1:0] addr_read,
    input  logic [width-1:0]         data_in,
    output logic [width-1:0]         data_out
);

    logic [width-1:0] mem [depth];              // maps to block ram

    // write port
    always_ff @(posedge clk_sys) begin
        if (we) begin
            mem[addr_write] <= data_in;
        end
    end

    // read port, one cycle latency
    always_ff @(posedge clk_sys) begin
        data_out <= mem[addr_read];             // old data on same-address write
    end

endmodule

//--- src/linebuffer.sv
// two-bank line store fed one framebuffer row at a time
// requests rows, accepts fills, replays pixels scaled
module linebuffer (
    input  logic                           clk_sys,
    input  logic                           rst_sys,
    input  logic                           frame,
    input  logic                           line,
    input  logic                           de,
    input  logic [display_pkg::scr_yw-1:0] sy,
    output logic                           data_req,  // ask for next row
    input  logic                           en_in,     // fill pixel valid
    input  logic [colour_pkg::chanw-1:0]   din_r,
    input  logic [colour_pkg::chanw-1:0]   din_g,
    input  logic [colour_pkg::chanw-1:0]   din_b,
    output logic [colour_pkg::chanw-1:0]   dout_r,
    output logic [colour_pkg::chanw-1:0]   dout_g,
    output logic [colour_pkg::chanw-1:0]   dout_b
);

    logic [colour_pkg::palw-1:0] mem [2][display_pkg::fb_width]; // two banks

    logic                                    bank_sel;  // front bank
    logic                                    front;     // front incl. swap now
    logic                                    swap_now;
    logic [$clog2(display_pkg::fb_width)-1:0] fill_ptr;
    logic                                    fill_busy;
    logic [$clog2(display_pkg::scale+1)-1:0] sub_cnt;   // repeats per pixel
    logic [$clog2(display_pkg::fb_width)-1:0] rd_idx;
    logic [$clog2(display_pkg::scale+1)-1:0] sub_cur;
    logic [$clog2(display_pkg::fb_width)-1:0] rd_cur;
    logic [colour_pkg::palw-1:0]             rd_word;

    // new row on every scale-th active line
    always_comb begin
        swap_now = line && (sy < display_pkg::v_active) && (sy % display_pkg::scale == 0);
        front    = swap_now ? !bank_sel : bank_sel;  // swap visible at x 0
        sub_cur  = line ? '0 : sub_cnt;              // line clears read position
        rd_cur   = line ? '0 : rd_idx;
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            data_req  <= 1'b0;
            bank_sel  <= 1'b0;
            fill_busy <= 1'b0;
            fill_ptr  <= '0;
            sub_cnt   <= '0;
            rd_idx    <= '0;
        end else begin
            // row 0 on frame, next row on last repeat of current one
            data_req <= frame || (line && (sy < display_pkg::v_active - display_pkg::scale)
                        && (sy % display_pkg::scale == display_pkg::scale - 1));
            bank_sel <= front;
            if (data_req) begin
                fill_busy <= 1'b1;
                fill_ptr  <= '0;
            end else if (en_in) begin
                fill_ptr <= fill_ptr + 1'b1;
                if (fill_ptr == display_pkg::fb_width - 1) begin
                    fill_busy <= 1'b0;          // row complete
                end
            end
            if (de) begin                       // one step per active pixel
                if (sub_cur == display_pkg::scale - 1) begin
                    sub_cnt <= '0;
                    rd_idx  <= rd_cur + 1'b1;   // wraps at end of line
                end else begin
                    sub_cnt <= sub_cur + 1'b1;
                    rd_idx  <= rd_cur;
                end
            end
        end
    end

    // fill back bank, read front bank
    always_ff @(posedge clk_sys) begin
        if (en_in) begin
            mem[!bank_sel][fill_ptr] <= {din_r, din_g, din_b};
        end
        rd_word <= mem[front][rd_cur];          // valid the cycle after de
    end

    always_comb begin
        dout_r = rd_word[colour_pkg::palw-1 -: colour_pkg::chanw];
        dout_g = rd_word[2*colour_pkg::chanw-1 -: colour_pkg::chanw];
        dout_b = rd_word[colour_pkg::chanw-1:0];
    end

    // fill source must honour the request protocol
    a_fill_in_request : assert property (
        @(posedge clk_sys) disable iff (rst_sys) en_in |-> fill_busy
    );
    a_req_when_idle : assert property (
        @(posedge clk_sys) disable iff (rst_sys) data_req |-> !fill_busy
    );

endmodule

//--- src/framebuffer_bram.sv
// indexed colour framebuffer: clipped write pipeline, row read sequencer,
// writable palette and line buffer feed, blanked colour outputs
module framebuffer_bram (
    input  logic                                  clk_sys,
    input  logic                                  rst_sys,
    input  logic                                  we,       // draw strobe
    input  logic signed [display_pkg::cordw-1:0]  x,
    input  logic signed [display_pkg::cordw-1:0]  y,
    input  logic [colour_pkg::cidxw-1:0]          cidx,
    input  logic                                  pal_we,
    input  logic [colour_pkg::cidxw-1:0]          pal_idx,
    input  logic [colour_pkg::palw-1:0]           pal_rgb,
    input  logic                                  de,
    input  logic                                  frame,
    input  logic                                  line,
    input  logic [display_pkg::scr_yw-1:0]        sy,
    output logic                                  clip,     // last x/y outside
    output logic [colour_pkg::chanw-1:0]          red,
    output logic [colour_pkg::chanw-1:0]          green,
    output logic [colour_pkg::chanw-1:0]          blue
);

    // write pipeline
    logic [display_pkg::fb_addrw-1:0]   wr_row;     // y * fb_width
    logic [display_pkg::fb_addrw-1:0]   wr_x;
    logic [colour_pkg::cidxw-1:0]       wr_cidx;
    logic                               we_p1;
    logic                               mem_we;
    logic [display_pkg::fb_addrw-1:0]   mem_addr_w;
    logic [colour_pkg::cidxw-1:0]       mem_din;

    // read side
    logic [display_pkg::fb_addrw-1:0]   rd_addr;
    logic [$clog2(display_pkg::fb_width)-1:0] rd_cnt;
    logic                               rd_busy;
    logic [colour_pkg::cidxw-1:0]       mem_dout;
    logic [colour_pkg::cidxw-1:0]       idx_p1;     // eases memory to palette path
    logic [display_pkg::fill_lat-1:0]   en_sr;      // valid follows the data
    logic [colour_pkg::palw-1:0]        palette [colour_pkg::pal_depth];

    // line buffer side
    logic                               lb_data_req;
    logic                               lb_en_in;
    logic [colour_pkg::chanw-1:0]       lb_in_r, lb_in_g, lb_in_b;
    logic [colour_pkg::chanw-1:0]       lb_out_r, lb_out_g, lb_out_b;
    logic                               de_p1;

    // address stages, no reset on payload
    always_ff @(posedge clk_sys) begin
        wr_row     <= display_pkg::fb_addrw'(y * display_pkg::fb_width); // negative y wraps
        wr_x       <= x[display_pkg::fb_addrw-1:0];
        wr_cidx    <= cidx;
        mem_addr_w <= wr_row + wr_x;                    // clipped writes never land
        mem_din    <= wr_cidx;
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            we_p1  <= 1'b0;
            clip   <= 1'b0;
            mem_we <= 1'b0;
        end else begin
            we_p1  <= we;
            clip   <= (x < 0) || (y < 0) || (x >= display_pkg::fb_width)
                      || (y >= display_pkg::fb_height);
            mem_we <= we_p1 && !clip;                   // drop out-of-range writes
        end
    end

    bram_sdp #(
        .width (colour_pkg::cidxw),
        .depth (display_pkg::fb_pixels)
    ) i_bram_sdp (
        .clk_sys    (clk_sys),
        .we         (mem_we),
        .addr_write (mem_addr_w),
        .addr_read  (rd_addr),
        .data_in    (mem_din),
        .data_out   (mem_dout)
    );

    // one row of fb_width reads per request, rows follow on
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            rd_busy <= 1'b0;
            rd_cnt  <= '0;
            rd_addr <= '0;
            en_sr   <= '0;
        end else begin
            if (lb_data_req) begin
                rd_busy <= 1'b1;
                rd_cnt  <= '0;
            end else if (rd_busy) begin
                rd_cnt  <= rd_cnt + 1'b1;
                rd_addr <= rd_addr + 1'b1;              // ends on next row start
                if (rd_cnt == display_pkg::fb_width - 1) begin
                    rd_busy <= 1'b0;
                end
            end
            if (frame) begin
                rd_addr <= '0;                          // row 0 requested next
            end
            en_sr <= {rd_busy, en_sr[display_pkg::fill_lat-1:1]};
        end
    end

    always_comb lb_en_in = en_sr[0];

    // palette write port and lookup
    always_ff @(posedge clk_sys) begin
        if (pal_we) begin
            palette[pal_idx] <= pal_rgb;
        end
        idx_p1 <= mem_dout;
        {lb_in_r, lb_in_g, lb_in_b} <= palette[idx_p1]; // red in top bits
    end

    linebuffer i_linebuffer (
        .clk_sys  (clk_sys),
        .rst_sys  (rst_sys),
        .frame    (frame),
        .line     (line),
        .de       (de),
        .sy       (sy),
        .data_req (lb_data_req),
        .en_in    (lb_en_in),
        .din_r    (lb_in_r),
        .din_g    (lb_in_g),
        .din_b    (lb_in_b),
        .dout_r   (lb_out_r),
        .dout_g   (lb_out_g),
        .dout_b   (lb_out_b)
    );

    // line buffer read takes a cycle
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            de_p1 <= 1'b0;
        end else begin
            de_p1 <= de;
        end
    end

    always_comb begin
        red   = de_p1 ? lb_out_r : '0;                  // black in blanking
        green = de_p1 ? lb_out_g : '0;
        blue  = de_p1 ? lb_out_b : '0;
    end

    // a memory write needs an in-range draw strobe two cycles back
    a_clip_blocks_write : assert property (
        @(posedge clk_sys) disable iff (rst_sys)
        mem_we |-> $past(we, 2) && ($past(x, 2) >= 0) && ($past(y, 2) >= 0)
                   && ($past(x, 2) < display_pkg::fb_width)
                   && ($past(y, 2) < display_pkg::fb_height)
    );

endmodule

//--- src/video_subsystem_top.sv
// video subsystem top: screen timing, framebuffer,
// registered colour outputs with aligned data enable
module video_subsystem_top (
    input  logic                                 clk_sys,
    input  logic                                 rst_sys,
    input  logic                                 we,
    input  logic signed [display_pkg::cordw-1:0] x,
    input  logic signed [display_pkg::cordw-1:0] y,
    input  logic [colour_pkg::cidxw-1:0]         cidx,
    input  logic                                 pal_we,
    input  logic [colour_pkg::cidxw-1:0]         pal_idx,
    input  logic [colour_pkg::palw-1:0]          pal_rgb,
    output logic                                 clip,
    output logic                                 vid_de,
    output logic                                 frame,
    output logic [colour_pkg::chanw-1:0]         red,
    output logic [colour_pkg::chanw-1:0]         green,
    output logic [colour_pkg::chanw-1:0]         blue
);

    logic                              de;
    logic                              line;
    logic [display_pkg::scr_yw-1:0]    sy;
    logic                              de_p1;           // matches framebuffer delay
    logic [colour_pkg::chanw-1:0]      fb_red, fb_green, fb_blue;

    display_timing i_display_timing (
        .clk_sys (clk_sys),
        .rst_sys (rst_sys),
        .de      (de),
        .frame   (frame),
        .line    (line),
        .sy      (sy)
    );

    framebuffer_bram i_framebuffer_bram (
        .clk_sys (clk_sys),
        .rst_sys (rst_sys),
        .we      (we),
        .x       (x),
        .y       (y),
        .cidx    (cidx),
        .pal_we  (pal_we),
        .pal_idx (pal_idx),
        .pal_rgb (pal_rgb),
        .de      (de),
        .frame   (frame),
        .line    (line),
        .sy      (sy),
        .clip    (clip),
        .red     (fb_red),
        .green   (fb_green),
        .blue    (fb_blue)
    );

    // framebuffer colours are combinational, register them here
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            de_p1  <= 1'b0;
            vid_de <= 1'b0;
            red    <= '0;
            green  <= '0;
            blue   <= '0;
        end else begin
            de_p1  <= de;
            vid_de <= de_p1;                            // two cycles after de
            red    <= fb_red;
            green  <= fb_green;
            blue   <= fb_blue;
        end
    end

endmodule

//--- verification/tb_video.sv
// testbench for the video subsystem: image and palette reference model,
// draw and palette stimulus, clip and pixel comparators, cycle timeout
module tb_video;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int active_pixels  = display_pkg::h_active * display_pkg::v_active;
    localparam int frame_cycles   = display_pkg::h_total * display_pkg::v_total;
    localparam int random_writes  = 64;
    localparam int checked_frames = 2;                  // old palette, then new palette
    localparam int timeout_cycles = 16 + 128 + random_writes + 5 * frame_cycles + 1000;
    // frame pulse to x 0 of the first blanking line
    localparam int blank_wait     = (display_pkg::v_active + 1) * display_pkg::h_total;

    logic                                 clk_sys;
    logic                                 rst_sys;
    logic                                 we;
    logic signed [display_pkg::cordw-1:0] x;
    logic signed [display_pkg::cordw-1:0] y;
    logic [colour_pkg::cidxw-1:0]         cidx;
    logic                                 pal_we;
    logic [colour_pkg::cidxw-1:0]         pal_idx;
    logic [colour_pkg::palw-1:0]          pal_rgb;
    logic                                 clip;
    logic                                 vid_de;
    logic                                 frame;
    logic [colour_pkg::chanw-1:0]         red, green, blue;

    logic [colour_pkg::cidxw-1:0] img_model [display_pkg::fb_pixels];  // row major
    logic [colour_pkg::palw-1:0]  pal_model [colour_pkg::pal_depth];

    int   de_count, pixels_checked, clip_checks, cycle_count;
    int   clip_errors, pixel_errors, blank_errors, misc_errors;
    logic frame_seen, checking, armed, clip_exp;

    video_subsystem_top i_video_subsystem_top (
        .clk_sys (clk_sys),
        .rst_sys (rst_sys),
        .we      (we),
        .x       (x),
        .y       (y),
        .cidx    (cidx),
        .pal_we  (pal_we),
        .pal_idx (pal_idx),
        .pal_rgb (pal_rgb),
        .clip    (clip),
        .vid_de  (vid_de),
        .frame   (frame),
        .red     (red),
        .green   (green),
        .blue    (blue)
    );

    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;                 // 20 ns period
    end

    // out of range in either axis, negative included
    function automatic logic ref_clip(input int px, input int py);
        return (px < 0) || (py < 0) || (px >= display_pkg::fb_width)
               || (py >= display_pkg::fb_height);
    endfunction

    // screen position back to buffer pixel, then palette
    function automatic logic [colour_pkg::palw-1:0] expected_rgb(input int sx, input int sy);
        int col;
        int row;
        col = sx / display_pkg::scale;
        row = sy / display_pkg::scale;
        return pal_model[img_model[row * display_pkg::fb_width + col]];
    endfunction

    task automatic report_mismatch(input string name, input int expv, input int actv);
        $display("ERROR %0t %s expected %0h actual %0h", $time, name, expv, actv);
    endtask

    task automatic draw_pixel(input int px, input int py, input logic [3:0] c);
        @(posedge clk_sys);
        we   <= 1'b1;
        x    <= display_pkg::cordw'(px);
        y    <= display_pkg::cordw'(py);
        cidx <= c;
        if (!ref_clip(px, py)) begin
            img_model[py * display_pkg::fb_width + px] = c;  // only in-range pixels land
        end
    endtask

    task automatic load_palette_entry(input int idx, input logic [11:0] rgb);
        @(posedge clk_sys);
        pal_we  <= 1'b1;
        pal_idx <= colour_pkg::cidxw'(idx);
        pal_rgb <= rgb;
        pal_model[idx] = rgb;
    endtask

    task automatic release_strobes();
        @(posedge clk_sys);
        we     <= 1'b0;
        pal_we <= 1'b0;
    endtask

    task automatic wait_frame_pulse();
        do @(negedge clk_sys); while (!frame);
    endtask

    // clip is registered, so it answers the x and y of the previous cycle
    always @(negedge clk_sys) begin
        if (!rst_sys) begin
            clip_checks++;
            if (clip !== clip_exp) begin
                report_mismatch("clip", clip_exp, clip);
                clip_errors++;
            end
        end
        clip_exp = ref_clip(x, y);
    end

    // screen position rebuilt from vid_de count since the last frame pulse
    always @(negedge clk_sys) begin
        logic [colour_pkg::palw-1:0] exp_rgb;
        if (!rst_sys) begin
            if (frame) begin
                if (frame_seen && de_count != active_pixels) begin
                    $display("frame ended at %0t with %0d vid_de cycles instead of %0d",
                             $time, de_count, active_pixels);
                    misc_errors++;
                end
                frame_seen = 1'b1;
                checking   = armed;                     // only frames after the last write
                de_count   = 0;
            end
            if (vid_de) begin
                if (checking && de_count < active_pixels) begin
                    exp_rgb = expected_rgb(de_count % display_pkg::h_active,
                                           de_count / display_pkg::h_active);
                    if (red !== exp_rgb[11:8]) begin
                        report_mismatch("red", exp_rgb[11:8], red);
                        pixel_errors++;
                    end
                    if (green !== exp_rgb[7:4]) begin
                        report_mismatch("green", exp_rgb[7:4], green);
                        pixel_errors++;
                    end
                    if (blue !== exp_rgb[3:0]) begin
                        report_mismatch("blue", exp_rgb[3:0], blue);
                        pixel_errors++;
                    end
                    pixels_checked++;
                end
                de_count++;
            end else if ({red, green, blue} !== '0) begin   // black in blanking
                report_mismatch("rgb", 0, {red, green, blue});
                blank_errors++;
            end
        end
    end

    initial begin
        while (cycle_count < timeout_cycles) begin
            @(posedge clk_sys);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the test sequence did not finish", timeout_cycles);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int   i;
        int   total;
        void'($urandom(32'ha4a61309));
        rst_sys = 1'b1;
        we      = 1'b0;
        x       = '0;
        y       = '0;
        cidx    = '0;
        pal_we  = 1'b0;
        pal_idx = '0;
        pal_rgb = '0;
        armed   = 1'b0;
        checking   = 1'b0;
        frame_seen = 1'b0;
        clip_exp   = 1'b0;
        repeat (8) @(posedge clk_sys);
        rst_sys <= 1'b0;

        // first frame is unchecked, all loading happens in it
        for (i = 0; i < colour_pkg::pal_depth; i++) begin
            load_palette_entry(i, colour_pkg::palw'($urandom()));
        end
        for (i = 0; i < display_pkg::fb_pixels; i++) begin
            draw_pixel(i % display_pkg::fb_width, i / display_pkg::fb_width,
                       colour_pkg::cidxw'($urandom()));
        end
        for (i = 0; i < random_writes; i++) begin   // over half land outside
            draw_pixel(int'($urandom_range(24, 0)) - 4, int'($urandom_range(14, 0)) - 3,
                       colour_pkg::cidxw'($urandom()));
        end
        release_strobes();
        armed = 1'b1;

        // frame two checked, then new palette in blanking
        wait_frame_pulse();
        repeat (blank_wait) @(posedge clk_sys);
        for (i = 0; i < colour_pkg::pal_depth; i++) begin
            load_palette_entry(i, colour_pkg::palw'($urandom()));
        end
        release_strobes();
        wait_frame_pulse();                             // frame three starts
        wait_frame_pulse();                             // its count is checked here
        repeat (2) @(posedge clk_sys);

        if (pixels_checked != checked_frames * active_pixels) begin
            $display("only %0d of %0d pixels were compared",
                     pixels_checked, checked_frames * active_pixels);
            misc_errors++;
        end
        if (clip_checks == 0) begin
            $display("clip was never compared");
            misc_errors++;
        end
        total = clip_errors + pixel_errors + blank_errors + misc_errors;
        $display("errors: clip %0d, pixel %0d, blanking %0d, other %0d",
                 clip_errors, pixel_errors, blank_errors, misc_errors);
        if (total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- tb.f
src/display_pkg.sv
src/colour_pkg.sv
src/display_timing.sv
src/bram_sdp.sv
src/linebuffer.sv
src/framebuffer_bram.sv
src/video_subsystem_top.sv
verification/tb_video.sv

//--- run_sim.sh
#!/bin/sh
# build the video subsystem testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_video -f tb.f \
    && ./obj_dir/Vtb_video | tee /dev/stderr | grep -q "Regression passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
